//--- source/memCtrlPkg.sv
package memCtrlPkg;

    // instruction and data words
    localparam int dataWidth = 32;

    // RAM data bus is one byte wide
    localparam int byteWidth = 8;

    // length field holds the number of bytes in a transfer
    localparam int lenWidth = 3;

    localparam logic [lenWidth-1:0] lenByte = 3'd1;
    localparam logic [lenWidth-1:0] lenHalf = 3'd2;
    localparam logic [lenWidth-1:0] lenWord = 3'd4;

    // which sequencer currently owns the RAM bus
    localparam int ownerWidth = 2;

    localparam logic [ownerWidth-1:0] ownerIdle  = 2'd0;
    localparam logic [ownerWidth-1:0] ownerData  = 2'd1;
    localparam logic [ownerWidth-1:0] ownerFetch = 2'd2;

endpackage

//--- source/fetchSequencer.sv
`timescale 1ns/100ps

module fetchSequencer #(
    parameter int addrWidth = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fetchEn,
    input  logic [addrWidth-1:0]                 fetchAddr,
    input  logic                                 fetchGrant,
    input  logic                                 step,
    input  logic [memCtrlPkg::byteWidth-1:0]     memDin,
    output logic                                 fetchReq,
    output logic [addrWidth-1:0]                 seqAddr,
    output logic                                 fetchDone,
    output logic [memCtrlPkg::dataWidth-1:0]     fetchInst
);
    localparam int stageWidth = memCtrlPkg::lenWidth;
    localparam logic [stageWidth-1:0] byteCount = memCtrlPkg::lenWord;
    // one stage for the RAM latency after the last address
    localparam logic [stageWidth-1:0] lastStage = byteCount + 3'd1;

    logic [stageWidth-1:0] stage;
    logic [1:0]            busIdx;
    logic                  busValid;
    logic [1:0]            rdIdx;
    logic                  rdValid;

    // the done cycle itself does not count as a request
    assign fetchReq = fetchEn & ~fetchDone;

    // fetchAddr is held stable by the requester until done
    assign seqAddr = fetchAddr + addrWidth'(stage);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage     <= '0;
            busValid  <= 1'b0;
            rdValid   <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            // RAM answers one cycle after the address, stalled or not
            rdValid <= busValid;
            if (fetchDone) begin
                stage     <= '0;
                fetchDone <= 1'b0;
            end else if (fetchGrant && step) begin
                stage     <= stage + 3'd1;
                busValid  <= stage < byteCount;
                fetchDone <= stage == lastStage;
            end
        end
    end

    // mirror of the byte index now sitting in memAddr
    always_ff @(posedge clk) begin
        rdIdx <= busIdx;
        if (fetchGrant && step) begin
            busIdx <= stage[1:0];
        end
    end

    // little endian, byte 0 lands in the low bits
    // a held address re-reads the same byte into the same slot
    always_ff @(posedge clk) begin
        if (rdValid) begin
            fetchInst[rdIdx*memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth] <= memDin;
        end
    end

endmodule

//--- source/dataSequencer.sv
`timescale 1ns/100ps

module dataSequencer #(
    parameter int addrWidth = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 dataEn,
    input  logic                                 dataStore,
    input  logic [memCtrlPkg::lenWidth-1:0]      dataLen,
    input  logic [addrWidth-1:0]                 dataAddr,
    input  logic [memCtrlPkg::dataWidth-1:0]     dataWdata,
    input  logic                                 dataGrant,
    input  logic                                 step,
    input  logic [memCtrlPkg::byteWidth-1:0]     memDin,
    output logic                                 dataReq,
    output logic [addrWidth-1:0]                 seqAddr,
    output logic [memCtrlPkg::byteWidth-1:0]     seqWdata,
    output logic                                 seqWrite,
    output logic                                 dataDone,
    output logic [memCtrlPkg::dataWidth-1:0]     dataRdata
);
    localparam int stageWidth = memCtrlPkg::lenWidth;
    localparam int byteWidth  = memCtrlPkg::byteWidth;

    // request fields, latched up to the grant edge
    logic                                 storeQ;
    logic [memCtrlPkg::lenWidth-1:0]      lenQ;
    logic [addrWidth-1:0]                 addrQ;
    logic [memCtrlPkg::dataWidth-1:0]     wdataQ;

    logic [stageWidth-1:0] stage;
    logic [stageWidth-1:0] lastStage;
    logic                  issuing;
    logic [1:0]            busIdx;
    logic                  busValid;
    logic [1:0]            rdIdx;
    logic                  rdValid;

    assign dataReq = dataEn & ~dataDone;

    // stages 0 .. len-1 put one byte each on the bus
    assign issuing = stage < lenQ;

    // loads need one extra stage for the RAM latency
    assign lastStage = storeQ ? lenQ : lenQ + 3'd1;

    assign seqAddr  = addrQ + addrWidth'(stage);
    assign seqWdata = wdataQ[stage[1:0]*byteWidth +: byteWidth];
    assign seqWrite = dataGrant & storeQ & issuing;

    always_ff @(posedge clk) begin
        if (!dataGrant) begin
            storeQ <= dataStore;
            lenQ   <= dataLen;
            addrQ  <= dataAddr;
            wdataQ <= dataWdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage    <= '0;
            busValid <= 1'b0;
            rdValid  <= 1'b0;
            dataDone <= 1'b0;
        end else begin
            rdValid <= busValid;
            if (dataDone) begin
                stage    <= '0;
                dataDone <= 1'b0;
            end else if (dataGrant && step) begin
                stage    <= stage + 3'd1;
                // stores never read back
                busValid <= ~storeQ & issuing;
                dataDone <= stage == lastStage;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdIdx <= busIdx;
        if (dataGrant && step) begin
            busIdx <= stage[1:0];
        end
    end

    // cleared before each transfer so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (!dataGrant) begin
            dataRdata <= '0;
        end else if (rdValid) begin
            dataRdata[rdIdx*byteWidth +: byteWidth] <= memDin;
        end
    end

endmodule

//--- source/ramArbiter.sv
`timescale 1ns/100ps

module ramArbiter #(
    parameter int addrWidth = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 rdy,
    input  logic                                 ioBufferFull,
    input  logic                                 fetchReq,
    input  logic                                 dataReq,
    input  logic                                 fetchFinish,
    input  logic                                 dataFinish,
    input  logic [addrWidth-1:0]                 fetchSeqAddr,
    input  logic [addrWidth-1:0]                 dataSeqAddr,
    input  logic [memCtrlPkg::byteWidth-1:0]     dataSeqWdata,
    input  logic                                 dataSeqWrite,
    output logic                                 fetchGrant,
    output logic                                 dataGrant,
    output logic                                 step,
    output logic [addrWidth-1:0]                 memAddr,
    output logic [memCtrlPkg::byteWidth-1:0]     memDout,
    output logic                                 memWr,
    output logic [memCtrlPkg::ownerWidth-1:0]    busOwner
);
    logic [memCtrlPkg::ownerWidth-1:0] owner;
    logic                              memWrQ;

    // either stall source freezes everything
    assign step = rdy & ~ioBufferFull;

    assign busOwner   = owner;
    assign dataGrant  = owner == memCtrlPkg::ownerData;
    assign fetchGrant = owner == memCtrlPkg::ownerFetch;

    // a held write must not hit the RAM twice
    assign memWr = memWrQ & step;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner  <= memCtrlPkg::ownerIdle;
            memWrQ <= 1'b0;
        end else begin
            case (owner)
                memCtrlPkg::ownerIdle: begin
                    // data side wins a tie
                    if (step && dataReq) begin
                        owner <= memCtrlPkg::ownerData;
                    end else if (step && fetchReq) begin
                        owner <= memCtrlPkg::ownerFetch;
                    end
                end
                memCtrlPkg::ownerData: begin
                    if (dataFinish) begin
                        owner <= memCtrlPkg::ownerIdle;
                    end
                end
                memCtrlPkg::ownerFetch: begin
                    if (fetchFinish) begin
                        owner <= memCtrlPkg::ownerIdle;
                    end
                end
                default: begin
                    owner <= memCtrlPkg::ownerIdle;
                end
            endcase
            if (step) begin
                memWrQ <= dataGrant & dataSeqWrite;
            end
        end
    end

    // bus registers hold through a stall
    always_ff @(posedge clk) begin
        if (step) begin
            memAddr <= dataGrant ? dataSeqAddr : fetchSeqAddr;
            memDout <= dataSeqWdata;
        end
    end

endmodule

//--- source/memCtrl.sv
`timescale 1ns/100ps

module memCtrl #(
    parameter int addrWidth = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 rdy,
    input  logic                                 ioBufferFull,
    input  logic                                 fetchEn,
    input  logic [addrWidth-1:0]                 fetchAddr,
    output logic                                 fetchDone,
    output logic [memCtrlPkg::dataWidth-1:0]     fetchInst,
    input  logic                                 dataEn,
    input  logic                                 dataStore,
    input  logic [memCtrlPkg::lenWidth-1:0]      dataLen,
    input  logic [addrWidth-1:0]                 dataAddr,
    input  logic [memCtrlPkg::dataWidth-1:0]     dataWdata,
    output logic                                 dataDone,
    output logic [memCtrlPkg::dataWidth-1:0]     dataRdata,
    input  logic [memCtrlPkg::byteWidth-1:0]     memDin,
    output logic [addrWidth-1:0]                 memAddr,
    output logic [memCtrlPkg::byteWidth-1:0]     memDout,
    output logic                                 memWr,
    output logic [memCtrlPkg::ownerWidth-1:0]    busOwner
);
    logic                             fetchReq;
    logic                             dataReq;
    logic                             fetchGrant;
    logic                             dataGrant;
    logic                             step;
    logic [addrWidth-1:0]             fetchSeqAddr;
    logic [addrWidth-1:0]             dataSeqAddr;
    logic [memCtrlPkg::byteWidth-1:0] dataSeqWdata;
    logic                             dataSeqWrite;

    fetchSequencer #(
        .addrWidth(addrWidth)
    ) fetchSeq (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchGrant(fetchGrant),
        .step      (step),
        .memDin    (memDin),
        .fetchReq  (fetchReq),
        .seqAddr   (fetchSeqAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataSequencer #(
        .addrWidth(addrWidth)
    ) dataSeq (
        .clk      (clk),
        .rst      (rst),
        .dataEn   (dataEn),
        .dataStore(dataStore),
        .dataLen  (dataLen),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataGrant(dataGrant),
        .step     (step),
        .memDin   (memDin),
        .dataReq  (dataReq),
        .seqAddr  (dataSeqAddr),
        .seqWdata (dataSeqWdata),
        .seqWrite (dataSeqWrite),
        .dataDone (dataDone),
        .dataRdata(dataRdata)
    );

    // done pulses double as the release for the bus
    ramArbiter #(
        .addrWidth(addrWidth)
    ) arbiter (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .fetchReq    (fetchReq),
        .dataReq     (dataReq),
        .fetchFinish (fetchDone),
        .dataFinish  (dataDone),
        .fetchSeqAddr(fetchSeqAddr),
        .dataSeqAddr (dataSeqAddr),
        .dataSeqWdata(dataSeqWdata),
        .dataSeqWrite(dataSeqWrite),
        .fetchGrant  (fetchGrant),
        .dataGrant   (dataGrant),
        .step        (step),
        .memAddr     (memAddr),
        .memDout     (memDout),
        .memWr       (memWr),
        .busOwner    (busOwner)
    );

endmodule

//--- verification/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verification/ramModel.sv
`timescale 1ns/100ps

module ramModel #(
    parameter int addrWidth = 32,
    parameter int depth = 1024
) (
    input  logic                             clk,
    input  logic [addrWidth-1:0]             addr,
    input  logic [memCtrlPkg::byteWidth-1:0] din,
    input  logic                             wr,
    output logic [memCtrlPkg::byteWidth-1:0] dout
);
    logic [memCtrlPkg::byteWidth-1:0] mem [depth];
    int writeCount = 0;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr % depth] <= din;
            writeCount <= writeCount + 1;
        end
        dout <= mem[addr % depth];
    end

    task automatic backdoorWrite(input int a, input logic [memCtrlPkg::byteWidth-1:0] d);
        mem[a] = d;
    endtask

    function automatic logic [memCtrlPkg::byteWidth-1:0] backdoorRead(input int a);
        return mem[a];
    endfunction

endmodule

//--- verification/memCtrlChecker.sv
`timescale 1ns/100ps

module memCtrlChecker (
    input logic                              clk,
    input logic                              rst,
    input logic                              memWr,
    input logic                              fetchDone,
    input logic                              dataDone,
    input logic [memCtrlPkg::ownerWidth-1:0] busOwner
);
    int failCount = 0;

    // only the data port ever writes
    writeOwner: assert property (@(posedge clk) disable iff (rst)
        memWr |-> busOwner == memCtrlPkg::ownerData)
        else begin
            $error("memWr high while the data port does not own the bus");
            failCount++;
        end

    oneDone: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
        else begin
            $error("fetchDone and dataDone high in the same cycle");
            failCount++;
        end

    // no direct handover between the ports
    ownerViaIdle: assert property (@(posedge clk) disable iff (rst)
        busOwner != $past(busOwner) |->
            ($past(busOwner) == memCtrlPkg::ownerIdle || busOwner == memCtrlPkg::ownerIdle))
        else begin
            $error("busOwner changed without passing through idle");
            failCount++;
        end

endmodule

//--- verification/memCtrlTb.sv
`timescale 1ns/100ps

module memCtrlTb;
    localparam int ramDepth = 1024;

    logic clk, rst, rdy, ioBufferFull;
    logic fetchEn, fetchDone, dataEn, dataStore, dataDone, memWr;
    logic [31:0] fetchAddr, dataAddr, memAddr;
    logic [memCtrlPkg::dataWidth-1:0] fetchInst, dataWdata, dataRdata;
    logic [memCtrlPkg::lenWidth-1:0] dataLen;
    logic [memCtrlPkg::byteWidth-1:0] memDin, memDout;
    logic [memCtrlPkg::ownerWidth-1:0] busOwner;
    logic [memCtrlPkg::byteWidth-1:0] shadow [ramDepth];
    int errorCount = 0;
    int timeoutCount = 0;

    clockGen clkGen (.clk(clk), .rst(rst));

    ramModel #(.addrWidth(32), .depth(ramDepth)) ram (
        .clk(clk), .addr(memAddr), .din(memDout), .wr(memWr), .dout(memDin)
    );

    memCtrl #(.addrWidth(32)) uut (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .fetchDone(fetchDone),
        .fetchInst(fetchInst), .dataEn(dataEn), .dataStore(dataStore),
        .dataLen(dataLen), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataDone(dataDone), .dataRdata(dataRdata), .memDin(memDin),
        .memAddr(memAddr), .memDout(memDout), .memWr(memWr), .busOwner(busOwner)
    );

    bind memCtrl memCtrlChecker chk (
        .clk(clk), .rst(rst), .memWr(memWr), .fetchDone(fetchDone),
        .dataDone(dataDone), .busOwner(busOwner)
    );

    task automatic compareWord(input string name, input logic [memCtrlPkg::dataWidth-1:0] exp,
                               input logic [memCtrlPkg::dataWidth-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic compareByte(input string name, input logic [memCtrlPkg::byteWidth-1:0] exp,
                               input logic [memCtrlPkg::byteWidth-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic compareOwner(input string name, input logic [memCtrlPkg::ownerWidth-1:0] exp,
                                input logic [memCtrlPkg::ownerWidth-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic compareCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errorCount++;
        end
    endtask

    function automatic logic [memCtrlPkg::dataWidth-1:0] shadowWord(input int a, input int len);
        logic [memCtrlPkg::dataWidth-1:0] r;
        r = '0;
        for (int i = 0; i < len; i++) begin
            r[i*8 +: 8] = shadow[a + i];
        end
        return r;
    endfunction

    task automatic waitOwner(input logic [memCtrlPkg::ownerWidth-1:0] exp, output bit ok);
        ok = 0;
        for (int i = 0; i < 50 && !ok; i++) begin
            @(negedge clk);
            ok = busOwner == exp;
        end
        if (!ok) begin
            $display("timeout at %0t: bus was never granted to owner %0d", $time, exp);
            timeoutCount++;
        end
    endtask

    // counts edges after the grant edge, optionally throwing in stall cycles
    task automatic waitDone(input bit isFetch, input bit stallOn,
                            input logic [memCtrlPkg::ownerWidth-1:0] owner,
                            output int edges, output int stalls);
        bit seen;
        seen = 0;
        edges = 0;
        stalls = 0;
        for (int i = 0; i < 200 && !seen; i++) begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
            if (stallOn && ($urandom % 3 == 0)) begin
                if ($urandom % 2) rdy = 1'b0;
                else ioBufferFull = 1'b1;
                stalls++;
            end
            @(negedge clk);
            edges++;
            seen = isFetch ? fetchDone : dataDone;
            if (!seen) compareOwner("busOwner", owner, busOwner);
        end
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        if (!seen) begin
            $display("timeout at %0t: no done pulse from the %s port", $time,
                     isFetch ? "fetch" : "data");
            timeoutCount++;
        end
    endtask

    task automatic runFetch(input int a, input bit stallOn);
        bit ok;
        int edges, stalls;
        @(negedge clk);
        fetchAddr = a;
        fetchEn = 1'b1;
        waitOwner(memCtrlPkg::ownerFetch, ok);
        if (ok) begin
            waitDone(1, stallOn, memCtrlPkg::ownerFetch, edges, stalls);
            compareWord("fetchInst", shadowWord(a, 4), fetchInst);
            compareCount("fetch latency", 6 + stalls, edges);
        end
        fetchEn = 1'b0;
    endtask

    task automatic runData(input bit store, input int len, input int a,
                           input logic [31:0] wdata, input bit stallOn);
        bit ok;
        int edges, stalls, writesBefore;
        @(negedge clk);
        writesBefore = ram.writeCount;
        dataStore = store;
        dataLen = len;
        dataAddr = a;
        dataWdata = wdata;
        dataEn = 1'b1;
        waitOwner(memCtrlPkg::ownerData, ok);
        if (ok) begin
            waitDone(0, stallOn, memCtrlPkg::ownerData, edges, stalls);
            compareCount("data latency", (store ? len + 1 : len + 2) + stalls, edges);
            if (store) begin
                for (int i = 0; i < len; i++) shadow[a + i] = wdata[i*8 +: 8];
                compareCount("ram write count", len, ram.writeCount - writesBefore);
                for (int i = 0; i < 4; i++) begin
                    compareByte("ram byte", shadow[a + i], ram.backdoorRead(a + i));
                end
            end else begin
                compareWord("dataRdata", shadowWord(a, len), dataRdata);
            end
        end
        dataEn = 1'b0;
    endtask

    function automatic int randLen();
        int pick;
        pick = $urandom % 3;
        return pick == 0 ? 1 : (pick == 1 ? 2 : 4);
    endfunction

    task automatic testSimultaneous(input int fa, input int da);
        bit ok;
        int edges, stalls;
        @(negedge clk);
        fetchAddr = fa;
        fetchEn = 1'b1;
        dataStore = 1'b0;
        dataLen = memCtrlPkg::lenWord;
        dataAddr = da;
        dataEn = 1'b1;
        // both requests reach the arbiter on the same edge
        @(negedge clk);
        compareOwner("busOwner", memCtrlPkg::ownerData, busOwner);
        waitDone(0, 0, memCtrlPkg::ownerData, edges, stalls);
        compareWord("dataRdata", shadowWord(da, 4), dataRdata);
        dataEn = 1'b0;
        waitOwner(memCtrlPkg::ownerFetch, ok);
        if (ok) begin
            waitDone(1, 0, memCtrlPkg::ownerFetch, edges, stalls);
            compareWord("fetchInst", shadowWord(fa, 4), fetchInst);
        end
        fetchEn = 1'b0;
        dataEn = 1'b0;
    endtask

    task automatic checkIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            compareOwner("busOwner", memCtrlPkg::ownerIdle, busOwner);
            compareByte("fetchDone", 8'h00, 8'(fetchDone));
            compareByte("dataDone", 8'h00, 8'(dataDone));
            compareByte("memWr", 8'h00, 8'(memWr));
        end
    endtask

    initial begin
        void'($urandom(15687));
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = memCtrlPkg::lenWord;
        dataAddr = '0;
        dataWdata = '0;
        for (int i = 0; i < ramDepth; i++) begin
            shadow[i] = 8'($urandom);
            ram.backdoorWrite(i, shadow[i]);
        end
        for (int i = 0; i < 20 && rst !== 1'b0; i++) begin
            @(negedge clk);
        end
        if (rst !== 1'b0) begin
            $display("timeout at %0t: reset was never released", $time);
            timeoutCount++;
        end
        checkIdle(4);

        for (int i = 0; i < 4; i++) runFetch($urandom % (ramDepth - 4), 0);
        for (int i = 0; i < 6; i++) runData(0, (i % 3 == 0) ? 1 : ((i % 3 == 1) ? 2 : 4),
                                            $urandom % (ramDepth - 4), 32'h0, 0);
        for (int len = 1; len <= 4; len = len * 2) begin
            int a;
            a = $urandom % (ramDepth - 4);
            runData(1, len, a, $urandom, 0);
            runData(0, 4, a, 32'h0, 0);
        end
        for (int i = 0; i < 3; i++) begin
            testSimultaneous($urandom % (ramDepth - 4), $urandom % (ramDepth - 4));
        end
        // results under stalls must match the plain runs
        for (int i = 0; i < 8; i++) begin
            int a;
            a = $urandom % (ramDepth - 4);
            runData(1, randLen(), a, $urandom, 1);
            runData(0, randLen(), a, 32'h0, 1);
            runFetch(a, 1);
        end
        checkIdle(5);

        $display("checks done: %0d value errors, %0d timeouts, %0d assertion failures",
                 errorCount, timeoutCount, uut.chk.failCount);
        if (errorCount == 0 && timeoutCount == 0 && uut.chk.failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- memCtrl.f
source/memCtrlPkg.sv
source/fetchSequencer.sv
source/dataSequencer.sv
source/ramArbiter.sv
source/memCtrl.sv
verification/clockGen.sv
verification/ramModel.sv
verification/memCtrlChecker.sv
verification/memCtrlTb.sv
